// ==== design/axi_ni_defs.svh ====
// widths, depths and the address map of the AXI network-interface slave
// include wherever a macro below is referenced; the guard makes repeats harmless
`ifndef AXI_NI_DEFS_SVH
`define AXI_NI_DEFS_SVH

// ****************************************
// AXI bus widths
// ****************************************
`define AXI_ADDR_WIDTH      32
`define AXI_DATA_WIDTH      32
`define AXI_ALEN_WIDTH      8

// ****************************************
// virtual channels and queue depths
// ****************************************
`define N_VIRT_CHN          2
`define VC_WIDTH            1
// outstanding transactions per direction
`define AXI_MAX_OUTSTD_WR   2
`define AXI_MAX_OUTSTD_RD   2
// flits held per channel on the receive side
`define RX_BUFF_DEPTH       4

// ****************************************
// address map
// ****************************************
// buffer of vc k sits at base + 8*k
`define AXI_WR_BFF_BASE     16'h1000
`define AXI_RD_BFF_BASE     16'h2000

`endif

// ==== design/axi_ni_pkg.sv ====
// types shared by the NI slave units and the request decoder
// modules import it inside their body and use scoped names on their ports
`include "axi_ni_defs.svh"

package axi_ni_pkg;

  typedef enum logic [1:0] {FIXED = 2'b00, INCR = 2'b01, WRAP = 2'b10} burst_t;
  typedef enum logic [1:0] {OKAY = 2'b00, SLVERR = 2'b10} aerror_t;
  // NONE doubles as the unmapped marker
  typedef enum logic [1:0] {NONE, NOC_WR_FIFOS, NOC_RD_FIFOS} region_t;

  typedef logic [`AXI_ADDR_WIDTH-1:0] axi_addr_t;
  typedef logic [`AXI_ALEN_WIDTH-1:0] alen_t;
  typedef logic [`VC_WIDTH-1:0]       vc_t;
  typedef logic [`AXI_DATA_WIDTH-1:0] flit_t;
  // burst length in beats needs one bit more than alen
  typedef logic [`AXI_ALEN_WIDTH:0]   pkt_sz_t;

  // master to slave with all five channels in one word
  typedef struct packed {
    // write address
    logic      awvalid;
    axi_addr_t awaddr;
    alen_t     awlen;
    burst_t    awburst;
    // write data
    logic      wvalid;
    flit_t     wdata;
    logic      wlast;
    // write response
    logic      bready;
    // read address
    logic      arvalid;
    axi_addr_t araddr;
    alen_t     arlen;
    burst_t    arburst;
    // read data
    logic      rready;
  } axi_mosi_t;

  // slave to master
  typedef struct packed {
    logic    awready;
    logic    wready;
    logic    bvalid;
    aerror_t bresp;
    logic    arready;
    logic    rvalid;
    flit_t   rdata;
    aerror_t rresp;
    logic    rlast;
  } axi_miso_t;

  // one outstanding request, already decoded
  typedef struct packed {
    region_t region;
    vc_t     vc_id;
    alen_t   alen;
    logic    error;
  } ot_req_t;

  typedef struct packed {
    logic    valid;
    vc_t     vc_id;
    logic    req_new;
    logic    req_last;
    pkt_sz_t pkt_sz;
    flit_t   flit_data;
  } pkt_out_req_t;

  typedef struct packed {
    logic  valid;
    vc_t   rq_vc;
    flit_t flit_data;
  } pkt_in_req_t;

  // address plus burst type to region and channel; alen is filled by the caller
  function automatic ot_req_t decode_addr(input axi_addr_t addr, input burst_t burst);
    ot_req_t req;
    req.region = NONE;
    req.vc_id  = '0;
    req.alen   = '0;
    for (int i = 0; i < `N_VIRT_CHN; i++) begin
      if (addr == axi_addr_t'(`AXI_WR_BFF_BASE + 8 * i)) begin
        req.region = NOC_WR_FIFOS;
        req.vc_id  = vc_t'(i);
      end else if (addr == axi_addr_t'(`AXI_RD_BFF_BASE + 8 * i)) begin
        req.region = NOC_RD_FIFOS;
        req.vc_id  = vc_t'(i);
      end
    end
    // only INCR bursts to a mapped buffer are served
    req.error = (burst != INCR) || (req.region == NONE);
    return req;
  endfunction

endpackage

// ==== design/ni_sync_fifo.sv ====
// single-clock circular FIFO, payload type chosen per instance
// holds outstanding AXI requests and the per-channel receive flits
// data_o shows the head entry whenever empty_o is low
`timescale 1ns/1ns

module ni_sync_fifo #(
  parameter int  SLOTS  = 2,
  parameter type T_DATA = logic
) (
  input  logic  clk_axi,
  input  logic  arst_axi,
  input  logic  write_i,
  input  logic  read_i,
  input  T_DATA data_i,
  output T_DATA data_o,
  output logic  full_o,
  output logic  empty_o
);
  localparam int PTR_W = (SLOTS > 1) ? $clog2(SLOTS) : 1;
  localparam int CNT_W = $clog2(SLOTS + 1);

  T_DATA            mem [SLOTS];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  // pointer advance, wraps for any depth
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(SLOTS - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // storage
  always_ff @(posedge clk_axi) begin
    if (write_i) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (write_i) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (read_i)  rd_ptr_q <= ptr_next(rd_ptr_q);
      // occupancy moves only when one side is active
      if (write_i && !read_i) begin
        count_q <= count_q + 1'b1;
      end else if (read_i && !write_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign data_o  = mem[rd_ptr_q];
  assign full_o  = (count_q == CNT_W'(SLOTS));
  assign empty_o = (count_q == '0);

  // callers must honour the flags they were given
  a_no_overflow: assert property (@(posedge clk_axi) disable iff (arst_axi)
    (write_i |-> !full_o) and (read_i |-> !empty_o));

endmodule

// ==== design/ni_wr_channel.sv ====
// write side of the NI slave
// AW requests are decoded on acceptance and queued, W beats of the head
// request leave as packet-out flits, each burst ends with one B response
// error requests swallow their beats and answer SLVERR
`timescale 1ns/1ns
`include "axi_ni_defs.svh"

module ni_wr_channel (
  input  logic                       clk_axi,
  input  logic                       arst_axi,
  input  axi_ni_pkg::axi_mosi_t      axi_mosi_i,
  input  logic                       pkt_out_ready_i,
  output logic                       awready_o,
  output logic                       wready_o,
  output logic                       bvalid_o,
  output axi_ni_pkg::aerror_t        bresp_o,
  output axi_ni_pkg::pkt_out_req_t   pkt_out_o
);
  import axi_ni_pkg::*;

  ot_req_t aw_req;
  ot_req_t head_req;
  logic    q_full;
  logic    q_empty;
  logic    aw_hs;
  logic    w_open;
  logic    w_hs;
  logic    last_hs;
  logic    b_stall;
  logic    head_flit_q;

  // ****************************************
  // AW acceptance and outstanding queue
  // ****************************************
  assign awready_o = !q_full;
  assign aw_hs     = axi_mosi_i.awvalid && awready_o;

  always_comb begin
    aw_req      = decode_addr(axi_mosi_i.awaddr, axi_mosi_i.awburst);
    aw_req.alen = axi_mosi_i.awlen;
    // a read buffer address is not writable
    aw_req.error = aw_req.error || (aw_req.region != NOC_WR_FIFOS);
  end

  ni_sync_fifo #(
    .SLOTS  (`AXI_MAX_OUTSTD_WR),
    .T_DATA (ot_req_t)
  ) u_wr_queue (
    .clk_axi  (clk_axi),
    .arst_axi (arst_axi),
    .write_i  (aw_hs),
    .read_i   (last_hs),
    .data_i   (aw_req),
    .data_o   (head_req),
    .full_o   (q_full),
    .empty_o  (q_empty)
  );

  // ****************************************
  // W beats to packet-out
  // ****************************************
  // a new last beat must wait while the previous B is still pending
  assign b_stall = bvalid_o && !axi_mosi_i.bready && axi_mosi_i.wlast;
  assign w_open  = !q_empty && !b_stall;

  // discarded beats are always taken, good ones wait on the packet side
  assign wready_o = w_open && (head_req.error || pkt_out_ready_i);
  assign w_hs     = axi_mosi_i.wvalid && wready_o;
  assign last_hs  = w_hs && axi_mosi_i.wlast;

  always_comb begin
    pkt_out_o.valid     = w_open && !head_req.error && axi_mosi_i.wvalid;
    pkt_out_o.vc_id     = head_req.vc_id;
    pkt_out_o.req_new   = head_flit_q;
    pkt_out_o.req_last  = axi_mosi_i.wlast;
    pkt_out_o.pkt_sz    = {1'b0, head_req.alen} + 1'b1;
    pkt_out_o.flit_data = axi_mosi_i.wdata;
  end

  // first beat after a wlast opens a new packet
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      head_flit_q <= 1'b1;
    end else if (w_hs) begin
      head_flit_q <= axi_mosi_i.wlast;
    end
  end

  // ****************************************
  // B response
  // ****************************************
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      bvalid_o <= 1'b0;
    end else if (last_hs) begin
      bvalid_o <= 1'b1;
    end else if (axi_mosi_i.bready) begin
      bvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_axi) begin
    if (last_hs) begin
      bresp_o <= head_req.error ? SLVERR : OKAY;
    end
  end

  // response is held with its code until the master takes it
  a_b_hold: assert property (@(posedge clk_axi) disable iff (arst_axi)
    bvalid_o && !axi_mosi_i.bready |=> bvalid_o && $stable(bresp_o));

endmodule

// ==== design/ni_rd_channel.sv ====
// read side of the NI slave
// AR requests are decoded on acceptance and queued; the head request
// becomes a transaction one cycle later and is served from the receive
// buffer of its channel, beat by beat as flits are available
// error requests and reads of an empty buffer give one SLVERR beat
`timescale 1ns/1ns
`include "axi_ni_defs.svh"

module ni_rd_channel (
  input  logic                       clk_axi,
  input  logic                       arst_axi,
  input  axi_ni_pkg::axi_mosi_t      axi_mosi_i,
  input  axi_ni_pkg::flit_t          rd_data_i,
  input  logic                       rd_empty_i,
  output logic                       arready_o,
  output logic                       rvalid_o,
  output axi_ni_pkg::flit_t          rdata_o,
  output axi_ni_pkg::aerror_t        rresp_o,
  output logic                       rlast_o,
  output logic [`VC_WIDTH-1:0]       rd_vc_o,
  output logic                       rd_pop_o
);
  import axi_ni_pkg::*;

  ot_req_t ar_req;
  ot_req_t head_req;
  logic    q_full;
  logic    q_empty;
  logic    ar_hs;
  logic    txn_q;
  logic    err_q;
  alen_t   beat_q;
  logic    data_beat;
  logic    r_hs;
  logic    r_done;

  // ****************************************
  // AR acceptance and outstanding queue
  // ****************************************
  assign arready_o = !q_full;
  assign ar_hs     = axi_mosi_i.arvalid && arready_o;

  always_comb begin
    ar_req      = decode_addr(axi_mosi_i.araddr, axi_mosi_i.arburst);
    ar_req.alen = axi_mosi_i.arlen;
    // write buffer addresses cannot be read
    ar_req.error = ar_req.error || (ar_req.region != NOC_RD_FIFOS);
  end

  ni_sync_fifo #(
    .SLOTS  (`AXI_MAX_OUTSTD_RD),
    .T_DATA (ot_req_t)
  ) u_rd_queue (
    .clk_axi  (clk_axi),
    .arst_axi (arst_axi),
    .write_i  (ar_hs),
    .read_i   (r_done),
    .data_i   (ar_req),
    .data_o   (head_req),
    .full_o   (q_full),
    .empty_o  (q_empty)
  );

  // ****************************************
  // transaction and beat counter
  // ****************************************
  // channel select comes straight from the head entry
  assign rd_vc_o = head_req.vc_id;

  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      txn_q  <= 1'b0;
      err_q  <= 1'b0;
      beat_q <= '0;
    end else if (!txn_q) begin
      // start once a request sits at the head
      if (!q_empty) begin
        txn_q  <= 1'b1;
        beat_q <= '0;
        // emptiness is sampled only here, at start
        err_q  <= head_req.error || rd_empty_i;
      end
    end else if (r_done) begin
      txn_q <= 1'b0;
    end else if (r_hs) begin
      beat_q <= beat_q + 1'b1;
    end
  end

  // ****************************************
  // R channel
  // ****************************************
  // data beats wait for a flit, so a dry buffer stalls the burst
  assign data_beat = txn_q && !err_q && !rd_empty_i;

  always_comb begin
    rvalid_o = data_beat || (txn_q && err_q);
    rlast_o  = (txn_q && err_q) || (data_beat && (beat_q == head_req.alen));
    rresp_o  = err_q ? SLVERR : OKAY;
    rdata_o  = data_beat ? rd_data_i : '0;
  end

  assign r_hs     = rvalid_o && axi_mosi_i.rready;
  assign r_done   = r_hs && rlast_o;
  // the head flit goes only on a data beat handshake
  assign rd_pop_o = data_beat && axi_mosi_i.rready;

  // a beat waiting on rready keeps its data, code and last flag
  a_r_hold: assert property (@(posedge clk_axi) disable iff (arst_axi)
    rvalid_o && !axi_mosi_i.rready |=> rvalid_o && $stable({rdata_o, rresp_o, rlast_o}));

endmodule

// ==== design/ni_rx_buffers.sv ====
// per virtual channel receive FIFOs between packet-in and the read channel
// a flit is stored in the FIFO named by rq_vc; the read channel picks
// one channel and sees its head flit and empty flag
// irq_o[k] is high while channel k holds a flit
`timescale 1ns/1ns
`include "axi_ni_defs.svh"

module ni_rx_buffers (
  input  logic                       clk_axi,
  input  logic                       arst_axi,
  input  axi_ni_pkg::pkt_in_req_t    pkt_in_i,
  input  logic [`VC_WIDTH-1:0]       rd_vc_i,
  input  logic                       rd_pop_i,
  output logic                       pkt_in_ready_o,
  output axi_ni_pkg::flit_t          rd_data_o,
  output logic                       rd_empty_o,
  output logic [`N_VIRT_CHN-1:0]     irq_o
);
  import axi_ni_pkg::*;

  logic  [`N_VIRT_CHN-1:0] vc_write;
  logic  [`N_VIRT_CHN-1:0] vc_read;
  logic  [`N_VIRT_CHN-1:0] vc_full;
  logic  [`N_VIRT_CHN-1:0] vc_empty;
  flit_t                   vc_data [`N_VIRT_CHN];

  // ****************************************
  // steering of writes and pops
  // ****************************************
  assign pkt_in_ready_o = !vc_full[pkt_in_i.rq_vc];

  always_comb begin
    for (int i = 0; i < `N_VIRT_CHN; i++) begin
      vc_write[i] = pkt_in_i.valid && (pkt_in_i.rq_vc == vc_t'(i)) && !vc_full[i];
      vc_read[i]  = rd_pop_i && (rd_vc_i == vc_t'(i));
    end
  end

  // ****************************************
  // channel buffers
  // ****************************************
  for (genvar g = 0; g < `N_VIRT_CHN; g++) begin : g_vc_buf
    ni_sync_fifo #(
      .SLOTS  (`RX_BUFF_DEPTH),
      .T_DATA (flit_t)
    ) u_vc_fifo (
      .clk_axi  (clk_axi),
      .arst_axi (arst_axi),
      .write_i  (vc_write[g]),
      .read_i   (vc_read[g]),
      .data_i   (pkt_in_i.flit_data),
      .data_o   (vc_data[g]),
      .full_o   (vc_full[g]),
      .empty_o  (vc_empty[g])
    );
  end

  // read side view of the selected channel
  assign rd_data_o  = vc_data[rd_vc_i];
  assign rd_empty_o = vc_empty[rd_vc_i];

  // one line per channel, follows the stored flag so it rises a cycle after the write
  assign irq_o = ~vc_empty;

endmodule

// ==== design/axi_ni_slave.sv ====
// top of the NI slave bridge: AXI4 port toward the processing element,
// packet-out and packet-in streams toward the NoC, one interrupt per VC
// everything runs on clk_axi
`timescale 1ns/1ns
`include "axi_ni_defs.svh"

module axi_ni_slave (
  input  logic                       clk_axi,
  input  logic                       arst_axi,
  input  axi_ni_pkg::axi_mosi_t      axi_mosi_i,
  output axi_ni_pkg::axi_miso_t      axi_miso_o,
  output axi_ni_pkg::pkt_out_req_t   pkt_out_o,
  input  logic                       pkt_out_ready_i,
  input  axi_ni_pkg::pkt_in_req_t    pkt_in_i,
  output logic                       pkt_in_ready_o,
  output logic [`N_VIRT_CHN-1:0]     irq_o
);
  import axi_ni_pkg::*;

  // write side responses
  logic                awready;
  logic                wready;
  logic                bvalid;
  aerror_t             bresp;
  // read side responses
  logic                arready;
  logic                rvalid;
  flit_t               rdata;
  aerror_t             rresp;
  logic                rlast;
  // read channel to receive buffers
  logic [`VC_WIDTH-1:0] rd_vc;
  logic                rd_pop;
  flit_t               rd_data;
  logic                rd_empty;

  ni_wr_channel u_wr_channel (
    .clk_axi         (clk_axi),
    .arst_axi        (arst_axi),
    .axi_mosi_i      (axi_mosi_i),
    .pkt_out_ready_i (pkt_out_ready_i),
    .awready_o       (awready),
    .wready_o        (wready),
    .bvalid_o        (bvalid),
    .bresp_o         (bresp),
    .pkt_out_o       (pkt_out_o)
  );

  ni_rd_channel u_rd_channel (
    .clk_axi    (clk_axi),
    .arst_axi   (arst_axi),
    .axi_mosi_i (axi_mosi_i),
    .rd_data_i  (rd_data),
    .rd_empty_i (rd_empty),
    .arready_o  (arready),
    .rvalid_o   (rvalid),
    .rdata_o    (rdata),
    .rresp_o    (rresp),
    .rlast_o    (rlast),
    .rd_vc_o    (rd_vc),
    .rd_pop_o   (rd_pop)
  );

  ni_rx_buffers u_rx_buffers (
    .clk_axi        (clk_axi),
    .arst_axi       (arst_axi),
    .pkt_in_i       (pkt_in_i),
    .rd_vc_i        (rd_vc),
    .rd_pop_i       (rd_pop),
    .pkt_in_ready_o (pkt_in_ready_o),
    .rd_data_o      (rd_data),
    .rd_empty_o     (rd_empty),
    .irq_o          (irq_o)
  );

  // ****************************************
  // merge of the slave-side AXI fields
  // ****************************************
  always_comb begin
    axi_miso_o.awready = awready;
    axi_miso_o.wready  = wready;
    axi_miso_o.bvalid  = bvalid;
    axi_miso_o.bresp   = bresp;
    axi_miso_o.arready = arready;
    axi_miso_o.rvalid  = rvalid;
    axi_miso_o.rdata   = rdata;
    axi_miso_o.rresp   = rresp;
    axi_miso_o.rlast   = rlast;
  end

endmodule

// ==== tb/tb_axi_ni_slave.sv ====
// testbench for the AXI NI slave bridge
// tasks drive AXI writes and reads and packet-in flits on the falling edge,
// per-channel scoreboard queues hold the expected traffic, and concurrent
// assertions compare the DUT against the heads of those queues
`timescale 1ns/1ns
`include "axi_ni_defs.svh"

module tb_axi_ni_slave;
  import axi_ni_pkg::*;

  localparam int        NVC        = `N_VIRT_CHN;
  localparam int        MAX_CYCLES = 4000;
  localparam axi_addr_t WR_BASE    = `AXI_WR_BFF_BASE;
  localparam axi_addr_t RD_BASE    = `AXI_RD_BFF_BASE;

  // one expected R beat with its vc kept to follow the buffer it drains
  typedef struct packed {
    vc_t     vc;
    logic    data_beat;
    flit_t   data;
    aerror_t resp;
    logic    last;
  } r_beat_t;

  logic           clk_axi       = 1'b0;
  logic           arst_axi      = 1'b1;
  axi_mosi_t      mst           = '0;
  axi_mosi_t      axi_mosi;
  axi_miso_t      axi_miso;
  pkt_out_req_t   pkt_out;
  logic           pkt_out_ready = 1'b0;
  pkt_in_req_t    pkt_in        = '0;
  logic           pkt_in_ready;
  logic [NVC-1:0] irq;
  logic           bready        = 1'b0;
  logic           rready        = 1'b0;

  // ****************************************
  // scoreboard
  // ****************************************
  pkt_out_req_t   out_exp_q [NVC][$];
  flit_t          rx_model_q [NVC][$];
  aerror_t        b_exp_q [$];
  r_beat_t        r_exp_q [$];
  int             rx_count [NVC];
  int             wr_inflight = 0;
  int             rd_inflight = 0;
  // queue heads as plain signals for the assertions
  pkt_out_req_t   out_head [NVC];
  logic [NVC-1:0] out_avail;
  aerror_t        b_head;
  logic           b_avail;
  r_beat_t        r_head;
  logic           r_avail;
  logic [NVC-1:0] rx_nonempty;
  logic [NVC-1:0] rx_full;

  logic [31:0]    data_state = 32'h8fd72bd0;
  logic [31:0]    thr_state  = 32'h8fd72bd0;
  int             err_cnt      = 0;
  int             err_mark     = 0;
  int             tests_run    = 0;
  int             tests_passed = 0;
  int             tests_failed = 0;
  int             cycles       = 0;

  always #4 clk_axi = ~clk_axi;

  // ready lines toward the DUT come from the throttle block
  always_comb begin
    axi_mosi        = mst;
    axi_mosi.bready = bready;
    axi_mosi.rready = rready;
  end

  axi_ni_slave DUT (
    .clk_axi         (clk_axi),
    .arst_axi        (arst_axi),
    .axi_mosi_i      (axi_mosi),
    .axi_miso_o      (axi_miso),
    .pkt_out_o       (pkt_out),
    .pkt_out_ready_i (pkt_out_ready),
    .pkt_in_i        (pkt_in),
    .pkt_in_ready_o  (pkt_in_ready),
    .irq_o           (irq)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rand_word();
    data_state = lcg_step(data_state);
    return data_state;
  endfunction

  // channel index of a buffer address or -1 for anything not served
  function automatic int target_vc(input axi_addr_t addr, input burst_t burst,
                                   input axi_addr_t base);
    if (burst != INCR) begin
      return -1;
    end
    for (int k = 0; k < NVC; k++) begin
      if (addr == base + axi_addr_t'(8 * k)) begin
        return k;
      end
    end
    return -1;
  endfunction

  function automatic void refresh_heads();
    for (int k = 0; k < NVC; k++) begin
      out_avail[k]   = out_exp_q[k].size() != 0;
      out_head[k]    = out_avail[k] ? out_exp_q[k][0] : '0;
      rx_nonempty[k] = rx_count[k] != 0;
      rx_full[k]     = rx_count[k] >= `RX_BUFF_DEPTH;
    end
    b_avail = b_exp_q.size() != 0;
    b_head  = b_avail ? b_exp_q[0] : OKAY;
    r_avail = r_exp_q.size() != 0;
    r_head  = r_avail ? r_exp_q[0] : '0;
  endfunction

  task automatic log_error(input string msg);
    err_cnt++;
    $display("FAILED at %0t ns: %s", $time, msg);
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_cnt == err_mark) begin
      tests_passed++;
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  // ****************************************
  // random back-pressure with about 3 cycles in 4 ready
  // ****************************************
  always @(negedge clk_axi) begin
    thr_state     = lcg_step(thr_state);
    pkt_out_ready = thr_state[31:30] != 2'b00;
    bready        = thr_state[29:28] != 2'b00;
    rready        = thr_state[27:26] != 2'b00;
  end

  // handshake monitor that retires expected entries
  always @(posedge clk_axi) begin
    r_beat_t rb;
    if (!arst_axi) begin
      if (pkt_out.valid && pkt_out_ready && out_avail[pkt_out.vc_id]) begin
        void'(out_exp_q[pkt_out.vc_id].pop_front());
      end
      if (pkt_in.valid && pkt_in_ready) begin
        rx_model_q[pkt_in.rq_vc].push_back(pkt_in.flit_data);
        rx_count[pkt_in.rq_vc]++;
      end
      if (axi_miso.bvalid && bready && b_avail) begin
        void'(b_exp_q.pop_front());
      end
      if (axi_miso.rvalid && rready && r_avail) begin
        rb = r_exp_q.pop_front();
        // only data beats take a flit out of the buffer
        if (rb.data_beat) begin
          rx_count[rb.vc]--;
        end
      end
      if (mst.awvalid && axi_miso.awready) wr_inflight++;
      if (mst.wvalid && axi_miso.wready && mst.wlast) wr_inflight--;
      if (mst.arvalid && axi_miso.arready) rd_inflight++;
      if (axi_miso.rvalid && rready && axi_miso.rlast) rd_inflight--;
      refresh_heads();
    end
  end

  always @(posedge clk_axi) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // ****************************************
  // checking assertions
  // ****************************************
  a_reset_state: assert property (@(posedge clk_axi) $fell(arst_axi) |->
      !axi_miso.bvalid && !axi_miso.rvalid && !pkt_out.valid && irq == '0 &&
      axi_miso.awready && axi_miso.arready)
    else log_error("outputs not idle after reset");

  a_pkt_out: assert property (@(posedge clk_axi) disable iff (arst_axi)
      pkt_out.valid && pkt_out_ready |->
      out_avail[pkt_out.vc_id] && pkt_out == out_head[pkt_out.vc_id])
    else log_error("packet-out flit differs from expected");

  a_b_resp: assert property (@(posedge clk_axi) disable iff (arst_axi)
      axi_miso.bvalid && bready |-> b_avail && axi_miso.bresp == b_head)
    else log_error("B response unexpected or wrong code");

  a_r_beat: assert property (@(posedge clk_axi) disable iff (arst_axi)
      axi_miso.rvalid && rready |-> r_avail && axi_miso.rdata == r_head.data &&
      axi_miso.rresp == r_head.resp && axi_miso.rlast == r_head.last)
    else log_error("R beat differs from expected");

  a_irq: assert property (@(posedge clk_axi) disable iff (arst_axi) irq == rx_nonempty)
    else log_error("interrupt lines differ from buffer occupancy");

  a_pkt_in_ready: assert property (@(posedge clk_axi) disable iff (arst_axi)
      pkt_in_ready == !rx_full[pkt_in.rq_vc])
    else log_error("packet-in ready differs from buffer fill");

  a_aw_ready: assert property (@(posedge clk_axi) disable iff (arst_axi)
      axi_miso.awready == (wr_inflight < `AXI_MAX_OUTSTD_WR))
    else log_error("awready differs from outstanding write count");

  a_ar_ready: assert property (@(posedge clk_axi) disable iff (arst_axi)
      axi_miso.arready == (rd_inflight < `AXI_MAX_OUTSTD_RD))
    else log_error("arready differs from outstanding read count");

  // ****************************************
  // traffic tasks entered and left on a falling edge
  // ****************************************
  task automatic aw_issue(input axi_addr_t addr, input burst_t burst, input int len);
    mst.awvalid = 1'b1;
    mst.awaddr  = addr;
    mst.awlen   = alen_t'(len);
    mst.awburst = burst;
    do @(posedge clk_axi); while (!axi_miso.awready);
    @(negedge clk_axi);
    mst.awvalid = 1'b0;
  endtask

  task automatic ar_issue(input axi_addr_t addr, input burst_t burst, input int len);
    mst.arvalid = 1'b1;
    mst.araddr  = addr;
    mst.arlen   = alen_t'(len);
    mst.arburst = burst;
    do @(posedge clk_axi); while (!axi_miso.arready);
    @(negedge clk_axi);
    mst.arvalid = 1'b0;
  endtask

  // vc below zero marks a burst that must not reach packet-out
  task automatic w_burst(input int vc, input int len);
    pkt_out_req_t exp;
    logic [31:0]  r;
    for (int i = 0; i <= len; i++) begin
      r = rand_word();
      // idle W cycles now and then
      while (r[31:30] == 2'b00) begin
        mst.wvalid = 1'b0;
        @(negedge clk_axi);
        r = rand_word();
      end
      mst.wvalid = 1'b1;
      mst.wdata  = rand_word();
      mst.wlast  = (i == len);
      if (vc >= 0) begin
        exp.valid     = 1'b1;
        exp.vc_id     = vc_t'(vc);
        exp.req_new   = (i == 0);
        exp.req_last  = (i == len);
        exp.pkt_sz    = pkt_sz_t'(len + 1);
        exp.flit_data = mst.wdata;
        out_exp_q[vc].push_back(exp);
        refresh_heads();
      end
      do @(posedge clk_axi); while (!axi_miso.wready);
      @(negedge clk_axi);
    end
    mst.wvalid = 1'b0;
    mst.wlast  = 1'b0;
  endtask

  task automatic write_burst(input axi_addr_t addr, input burst_t burst, input int len);
    int vc;
    vc = target_vc(addr, burst, WR_BASE);
    b_exp_q.push_back(vc < 0 ? SLVERR : OKAY);
    refresh_heads();
    aw_issue(addr, burst, len);
    w_burst(vc, len);
  endtask

  // both AW go before any W so two writes sit in the queue together
  task automatic write_pair(input axi_addr_t a0, input burst_t b0, input int l0,
                            input axi_addr_t a1, input burst_t b1, input int l1);
    int vc0;
    int vc1;
    vc0 = target_vc(a0, b0, WR_BASE);
    vc1 = target_vc(a1, b1, WR_BASE);
    b_exp_q.push_back(vc0 < 0 ? SLVERR : OKAY);
    b_exp_q.push_back(vc1 < 0 ? SLVERR : OKAY);
    refresh_heads();
    aw_issue(a0, b0, l0);
    aw_issue(a1, b1, l1);
    w_burst(vc0, l0);
    w_burst(vc1, l1);
  endtask

  // expected beats come from the stored flits of the target channel
  task automatic read_burst(input axi_addr_t addr, input burst_t burst, input int len);
    int      vc;
    r_beat_t exp;
    vc = target_vc(addr, burst, RD_BASE);
    if (vc >= 0 && rx_model_q[vc].size() != 0) begin
      for (int i = 0; i <= len; i++) begin
        exp.vc        = vc_t'(vc);
        exp.data_beat = 1'b1;
        exp.data      = rx_model_q[vc].pop_front();
        exp.resp      = OKAY;
        exp.last      = (i == len);
        r_exp_q.push_back(exp);
      end
    end else begin
      exp      = '0;
      exp.resp = SLVERR;
      exp.last = 1'b1;
      r_exp_q.push_back(exp);
    end
    refresh_heads();
    ar_issue(addr, burst, len);
  endtask

  task automatic rx_push(input int vc, input int n);
    for (int i = 0; i < n; i++) begin
      pkt_in.valid     = 1'b1;
      pkt_in.rq_vc     = vc_t'(vc);
      pkt_in.flit_data = rand_word();
      do @(posedge clk_axi); while (!pkt_in_ready);
      @(negedge clk_axi);
    end
    pkt_in.valid = 1'b0;
  endtask

  // offer a flit to a full channel for a few cycles, then give up
  task automatic rx_offer(input int vc, input int n);
    pkt_in.valid     = 1'b1;
    pkt_in.rq_vc     = vc_t'(vc);
    pkt_in.flit_data = rand_word();
    repeat (n) @(negedge clk_axi);
    pkt_in.valid = 1'b0;
  endtask

  task automatic drain();
    while (b_exp_q.size() != 0 || r_exp_q.size() != 0 ||
           out_exp_q[0].size() != 0 || out_exp_q[1].size() != 0) begin
      @(negedge clk_axi);
    end
  endtask

  // ****************************************
  // test sequence
  // ****************************************
  initial begin
    refresh_heads();
    repeat (4) @(posedge clk_axi);
    @(negedge clk_axi);
    arst_axi = 1'b0;
    repeat (3) @(negedge clk_axi);
    end_test("reset state");

    write_burst(WR_BASE, INCR, 0);
    write_burst(WR_BASE + 8, INCR, 3);
    write_burst(WR_BASE, INCR, 7);
    write_burst(WR_BASE + 8, INCR, 1);
    drain();
    end_test("valid writes");

    write_burst(WR_BASE, FIXED, 2);
    write_burst(WR_BASE + 8, WRAP, 1);
    write_burst(32'h0000_3000, INCR, 3);
    write_burst(RD_BASE, INCR, 0);
    drain();
    end_test("invalid writes");

    rx_push(0, 3);
    rx_push(1, `RX_BUFF_DEPTH);
    read_burst(RD_BASE + 8, INCR, `RX_BUFF_DEPTH - 1);
    read_burst(RD_BASE, INCR, 2);
    drain();
    rx_push(0, 2);
    read_burst(RD_BASE, INCR, 1);
    drain();
    end_test("receive and read back");

    read_burst(RD_BASE, INCR, 3);
    read_burst(RD_BASE + 8, FIXED, 0);
    read_burst(32'h0000_5000, INCR, 1);
    read_burst(WR_BASE, INCR, 0);
    drain();
    end_test("invalid reads");

    rx_push(1, `RX_BUFF_DEPTH);
    rx_offer(1, 3);
    read_burst(RD_BASE + 8, INCR, `RX_BUFF_DEPTH - 1);
    drain();
    write_pair(WR_BASE, INCR, 2, 32'h0000_3000, INCR, 1);
    drain();
    end_test("full buffer and queued writes");

    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_passed, tests_failed, err_cnt);
    if (tests_failed == 0 && err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+design
design/axi_ni_pkg.sv
design/ni_sync_fifo.sv
design/ni_wr_channel.sv
design/ni_rd_channel.sv
design/ni_rx_buffers.sv
design/axi_ni_slave.sv
tb/tb_axi_ni_slave.sv
